// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_cpu
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SOURCES := $(wildcard verilog/*.sv verilog/*.svh test/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

test: $(SIM_BIN)
	-$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "^Simulation passed$$" $(LOG); then \
		echo "test: PASS"; \
	else \
		echo "test: FAIL"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: list.f
+incdir+verilog
verilog/rv_core_pkg.sv
verilog/rv_isa_pkg.sv
verilog/regfile.sv
verilog/fetch.sv
verilog/decode.sv
verilog/execute.sv
verilog/commit.sv
verilog/cpu.sv
test/tb_clock.sv
test/tb_cpu.sv

// File: test/tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
  output logic clock_o,
  output logic rst_n_o
);

  // 20 ns period.
  initial begin
    clock_o = 1'b0;
    forever #10 clock_o = ~clock_o;
  end

  // low for the first 4 rising edges.
  initial begin
    rst_n_o = 1'b0;
    repeat (4) @(posedge clock_o);
    rst_n_o <= 1'b1;
  end

endmodule

// File: test/tb_cpu.sv
`timescale 1ns/100ps
`include "rv_config.svh"

module tb_cpu;

  import rv_core_pkg::*;

  localparam int PROG_WORDS     = 256;
  localparam int RETIRE_COUNT   = 2000;
  localparam int TIMEOUT_CYCLES = RETIRE_COUNT * 20 + 100;
  localparam int MAX_DELAY      = 5;

  typedef enum logic [2:0] {
    M_IDLE,
    M_AR_WAIT,
    M_AR_READY,
    M_R_WAIT,
    M_R_VALID
  } mem_state_t;

  logic        clock;
  logic        rst_n;
  logic        arready = 1'b0;
  logic        arvalid;
  addr_t       araddr;
  logic        rready;
  logic        rvalid = 1'b0;
  bus_data_t   rdata = '0;
  logic        commit_valid;
  addr_t       commit_pc;
  logic        commit_wena;
  reg_addr_t   commit_waddr;
  xlen_t       commit_wdata;

  integer      seed = 42;
  inst_t       prog [PROG_WORDS];
  xlen_t       model_regs [`RV_REG_COUNT];
  addr_t       model_pc;
  mem_state_t  mem_state;
  addr_t       req_addr;
  bus_data_t   next_beat;
  int unsigned wait_cnt;
  int unsigned fetch_count = 0;
  int unsigned retired = 0;
  int unsigned cycles = 0;

  tb_clock clock_gen (
    .clock_o (clock),
    .rst_n_o (rst_n)
  );

  cpu dut (
    .clock               (clock),
    .rst_n_i             (rst_n),
    .io_master_arready_i (arready),
    .io_master_arvalid_o (arvalid),
    .io_master_araddr_o  (araddr),
    .io_master_rready_o  (rready),
    .io_master_rvalid_i  (rvalid),
    .io_master_rdata_i   (rdata),
    .commit_valid_o      (commit_valid),
    .commit_pc_o         (commit_pc),
    .commit_wena_o       (commit_wena),
    .commit_waddr_o      (commit_waddr),
    .commit_wdata_o      (commit_wdata)
  );

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp)
      stop_on_error($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic check_word(input string name, input xlen_t got, input xlen_t exp);
    if (got !== exp)
      stop_on_error($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
    if (got !== exp)
      stop_on_error($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
      stop_on_error($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
  endtask

  function automatic int unsigned rand_below(int unsigned n);
    logic [31:0] r;
    r = $random(seed);
    return r % n;
  endfunction

  // x0 to x15 only, so that operands collide often.
  function automatic reg_addr_t rand_reg();
    logic [31:0] r;
    r = $random(seed);
    return {1'b0, r[3:0]};
  endfunction

  task automatic build_program();
    logic [31:0] r;
    logic [31:0] words;
    logic [12:0] boff;
    logic [20:0] joff;
    logic [2:0]  f3;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    int unsigned span;
    for (int i = 0; i < PROG_WORDS - 1; i++) begin
      r     = $random(seed);
      rd    = rand_reg();
      rs1   = rand_reg();
      rs2   = rand_reg();
      span  = (PROG_WORDS - 1 - i > 8) ? 8 : PROG_WORDS - 1 - i;
      words = 1 + rand_below(span);
      boff  = {words[10:0], 2'b00};
      joff  = {words[18:0], 2'b00};
      case (rand_below(10))
        0, 1, 2, 3: begin
          case (rand_below(5))
            0: f3 = 3'b000;
            1: f3 = 3'b010;
            2: f3 = 3'b100;
            3: f3 = 3'b110;
            default: f3 = 3'b111;
          endcase
          prog[i] = {r[11:0], rs1, f3, rd, 7'b0010011};
        end
        4, 5: begin
          // no sltu, and sub only with funct3 zero.
          f3 = (r[2:0] == 3'b011) ? 3'b000 : r[2:0];
          prog[i] = {1'b0, r[3] & (f3 == 3'b000), 5'b0, rs2, rs1, f3, rd, 7'b0110011};
        end
        6: prog[i] = {r[19:0], rd, 7'b0110111};
        7: prog[i] = {r[19:0], rd, 7'b0010111};
        8: prog[i] = {joff[20], joff[10:1], joff[11], joff[19:12], rd, 7'b1101111};
        default: begin
          f3 = {2'b00, r[0]};
          prog[i] = {boff[12], boff[10:5], rs2, rs1, f3, boff[4:1], boff[11], 7'b1100011};
        end
      endcase
    end
    // jal x0 to itself.
    prog[PROG_WORDS-1] = 32'h0000_006f;
  endtask

  task automatic fetch_word(input addr_t addr, output inst_t word);
    addr_t offset;
    offset = addr - `RV_RESET_PC;
    if (offset >= PROG_WORDS * 4)
      stop_on_error($sformatf("fetch address 0x%h lies outside the program", addr));
    word = prog[offset[9:2]];
  endtask

  task automatic read_beat(input addr_t addr, output bus_data_t beat);
    inst_t lo;
    inst_t hi;
    fetch_word({addr[31:3], 3'b000}, lo);
    fetch_word({addr[31:3], 3'b100}, hi);
    beat = {hi, lo};
  endtask

  function automatic xlen_t alu_ref(logic [2:0] f3, logic sub, xlen_t a, xlen_t b);
    case (f3)
      3'b000: return sub ? a - b : a + b;
      3'b001: return a << b[4:0];
      3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b100: return a ^ b;
      3'b101: return a >> b[4:0];
      3'b110: return a | b;
      default: return a & b;
    endcase
  endfunction

  // one step of the instruction-set model per retirement.
  task automatic retire_check();
    inst_t      inst;
    logic [2:0] f3;
    reg_addr_t  rd;
    xlen_t      a;
    xlen_t      b;
    xlen_t      imm_u;
    xlen_t      wdata;
    addr_t      npc;
    logic       wena;
    logic       is_branch;
    fetch_word(model_pc, inst);
    if (fetch_count != retired + 1)
      stop_on_error("retired instructions do not match the instructions read from memory");
    f3        = inst[14:12];
    rd        = inst[11:7];
    a         = model_regs[inst[19:15]];
    b         = model_regs[inst[24:20]];
    imm_u     = {inst[31:12], 12'h000};
    npc       = model_pc + 32'd4;
    wena      = 1'b1;
    wdata     = '0;
    is_branch = 1'b0;
    case (inst[6:0])
      7'b0010011: wdata = alu_ref(f3, 1'b0, a, {{20{inst[31]}}, inst[31:20]});
      7'b0110011: wdata = alu_ref(f3, inst[30], a, b);
      7'b0110111: wdata = imm_u;
      7'b0010111: wdata = model_pc + imm_u;
      7'b1101111: begin
        wdata = model_pc + 32'd4;
        npc   = model_pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      7'b1100011: begin
        wena      = 1'b0;
        is_branch = 1'b1;
        if ((f3 == 3'b000 && a == b) || (f3 == 3'b001 && a != b))
          npc = model_pc + {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      end
      default: stop_on_error("the model met an instruction outside the supported set");
    endcase
    if (rd == '0)
      wena = 1'b0;
    check_addr("commit_pc_o", commit_pc, model_pc);
    check_bit("commit_wena_o", commit_wena, wena);
    if (!is_branch) begin
      check_reg("commit_waddr_o", commit_waddr, rd);
      check_word("commit_wdata_o", commit_wdata, wdata);
    end
    if (wena)
      model_regs[rd] = wdata;
    model_pc = npc;
    retired  = retired + 1;
    if (retired == RETIRE_COUNT) begin
      $display("Simulation passed");
      $finish;
    end
  endtask

  initial build_program();

  initial begin : reset_checks
    @(posedge clock);
    do begin
      @(posedge clock);
      check_bit("io_master_arvalid_o", arvalid, 1'b0);
      check_bit("io_master_rready_o", rready, 1'b0);
      check_bit("commit_valid_o", commit_valid, 1'b0);
    end while (!rst_n);
    @(posedge clock);
    check_bit("io_master_arvalid_o", arvalid, 1'b1);
    check_addr("io_master_araddr_o", araddr, `RV_RESET_PC);
  end

  // memory with random latency on both channels.
  always @(posedge clock) begin
    if (!rst_n) begin
      arready   <= 1'b0;
      rvalid    <= 1'b0;
      mem_state <= M_IDLE;
    end else begin
      case (mem_state)
        M_IDLE: begin
          if (arvalid) begin
            check_addr("io_master_araddr_o", araddr, model_pc);
            req_addr  <= araddr;
            wait_cnt  <= rand_below(MAX_DELAY + 1);
            mem_state <= M_AR_WAIT;
          end
        end
        M_AR_WAIT: begin
          check_bit("io_master_arvalid_o", arvalid, 1'b1);
          check_addr("io_master_araddr_o", araddr, req_addr);
          if (wait_cnt == 0) begin
            arready   <= 1'b1;
            mem_state <= M_AR_READY;
          end else begin
            wait_cnt <= wait_cnt - 1;
          end
        end
        M_AR_READY: begin
          // address handshake at this edge.
          check_bit("io_master_arvalid_o", arvalid, 1'b1);
          check_addr("io_master_araddr_o", araddr, req_addr);
          arready   <= 1'b0;
          wait_cnt  <= rand_below(MAX_DELAY + 1);
          mem_state <= M_R_WAIT;
        end
        M_R_WAIT: begin
          check_bit("io_master_rready_o", rready, 1'b1);
          if (wait_cnt == 0) begin
            read_beat(req_addr, next_beat);
            rdata     <= next_beat;
            rvalid    <= 1'b1;
            mem_state <= M_R_VALID;
          end else begin
            wait_cnt <= wait_cnt - 1;
          end
        end
        default: begin
          check_bit("io_master_rready_o", rready, 1'b1);
          rvalid      <= 1'b0;
          fetch_count <= fetch_count + 1;
          mem_state   <= M_IDLE;
        end
      endcase
    end
  end

  always @(posedge clock) begin
    if (!rst_n) begin
      model_pc = `RV_RESET_PC;
      for (int i = 0; i < `RV_REG_COUNT; i++) begin
        model_regs[i] = '0;
      end
    end else if (commit_valid) begin
      retire_check();
    end
  end

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES)
      stop_on_error("timeout: the core did not reach the retirement count in time");
  end

endmodule

// File: verilog/commit.sv
`timescale 1ns/100ps

module commit (
  input  logic                   clock,
  input  logic                   rst_n_i,
  input  logic                   valid_i,
  input  rv_core_pkg::addr_t     pc_i,
  input  rv_core_pkg::xlen_t     result_i,
  input  rv_core_pkg::addr_t     next_pc_i,
  input  logic                   wena_i,
  input  rv_core_pkg::reg_addr_t waddr_i,
  output logic                   commit_valid_o,
  output rv_core_pkg::addr_t     next_pc_o,
  output logic                   wena_o,
  output rv_core_pkg::reg_addr_t waddr_o,
  output rv_core_pkg::xlen_t     wdata_o,
  output rv_core_pkg::addr_t     commit_pc_o
);

  // write enable is a pulse, aligned with the retire.
  always_ff @(posedge clock) begin
    if (!rst_n_i) begin
      commit_valid_o <= 1'b0;
      wena_o         <= 1'b0;
    end else begin
      commit_valid_o <= valid_i;
      wena_o         <= valid_i && wena_i;
    end
  end

  always_ff @(posedge clock) begin
    if (valid_i) begin
      commit_pc_o <= pc_i;
      next_pc_o   <= next_pc_i;
      waddr_o     <= waddr_i;
      wdata_o     <= result_i;
    end
  end

endmodule

// File: verilog/cpu.sv
`timescale 1ns/100ps

module cpu (
  input  logic                  clock,
  input  logic                  rst_n_i,
  input  logic                  io_master_arready_i,
  output logic                  io_master_arvalid_o,
  output rv_core_pkg::addr_t    io_master_araddr_o,
  output logic                  io_master_rready_o,
  input  logic                  io_master_rvalid_i,
  input  rv_core_pkg::bus_data_t io_master_rdata_i,
  output logic                  commit_valid_o,
  output rv_core_pkg::addr_t    commit_pc_o,
  output logic                  commit_wena_o,
  output rv_core_pkg::reg_addr_t commit_waddr_o,
  output rv_core_pkg::xlen_t    commit_wdata_o
);

  import rv_core_pkg::*;
  import rv_isa_pkg::*;

  // fetch to decode.
  logic      dec_valid;
  addr_t     dec_pc;
  inst_t     dec_inst;

  // decode to execute.
  logic      exe_valid;
  addr_t     exe_pc;
  xlen_t     exe_imm;
  xlen_t     exe_rdata1;
  xlen_t     exe_rdata2;
  alu_op_t   exe_alu_op;
  br_op_t    exe_br_op;
  logic      exe_sel_pc;
  logic      exe_sel_imm;
  logic      exe_wena;
  reg_addr_t exe_waddr;

  // execute to commit.
  logic      cmt_valid;
  addr_t     cmt_pc;
  xlen_t     cmt_result;
  addr_t     cmt_next_pc;
  logic      cmt_wena;
  reg_addr_t cmt_waddr;

  // commit back to fetch.
  addr_t     next_pc;

  fetch fetch0 (
    .clock          (clock),
    .rst_n_i        (rst_n_i),
    .commit_valid_i (commit_valid_o),
    .next_pc_i      (next_pc),
    .arready_i      (io_master_arready_i),
    .arvalid_o      (io_master_arvalid_o),
    .araddr_o       (io_master_araddr_o),
    .rready_o       (io_master_rready_o),
    .rvalid_i       (io_master_rvalid_i),
    .rdata_i        (io_master_rdata_i),
    .valid_o        (dec_valid),
    .pc_o           (dec_pc),
    .inst_o         (dec_inst)
  );

  decode decode0 (
    .clock     (clock),
    .rst_n_i   (rst_n_i),
    .valid_i   (dec_valid),
    .pc_i      (dec_pc),
    .inst_i    (dec_inst),
    .wena_i    (commit_wena_o),
    .waddr_i   (commit_waddr_o),
    .wdata_i   (commit_wdata_o),
    .valid_o   (exe_valid),
    .pc_o      (exe_pc),
    .imm_o     (exe_imm),
    .rdata1_o  (exe_rdata1),
    .rdata2_o  (exe_rdata2),
    .alu_op_o  (exe_alu_op),
    .br_op_o   (exe_br_op),
    .sel_pc_o  (exe_sel_pc),
    .sel_imm_o (exe_sel_imm),
    .wena_o    (exe_wena),
    .waddr_o   (exe_waddr)
  );

  execute execute0 (
    .clock     (clock),
    .rst_n_i   (rst_n_i),
    .valid_i   (exe_valid),
    .pc_i      (exe_pc),
    .imm_i     (exe_imm),
    .rdata1_i  (exe_rdata1),
    .rdata2_i  (exe_rdata2),
    .alu_op_i  (exe_alu_op),
    .br_op_i   (exe_br_op),
    .sel_pc_i  (exe_sel_pc),
    .sel_imm_i (exe_sel_imm),
    .wena_i    (exe_wena),
    .waddr_i   (exe_waddr),
    .valid_o   (cmt_valid),
    .pc_o      (cmt_pc),
    .result_o  (cmt_result),
    .next_pc_o (cmt_next_pc),
    .wena_o    (cmt_wena),
    .waddr_o   (cmt_waddr)
  );

  commit commit0 (
    .clock          (clock),
    .rst_n_i        (rst_n_i),
    .valid_i        (cmt_valid),
    .pc_i           (cmt_pc),
    .result_i       (cmt_result),
    .next_pc_i      (cmt_next_pc),
    .wena_i         (cmt_wena),
    .waddr_i        (cmt_waddr),
    .commit_valid_o (commit_valid_o),
    .next_pc_o      (next_pc),
    .wena_o         (commit_wena_o),
    .waddr_o        (commit_waddr_o),
    .wdata_o        (commit_wdata_o),
    .commit_pc_o    (commit_pc_o)
  );

endmodule

// File: verilog/decode.sv
`timescale 1ns/100ps

module decode (
  input  logic                   clock,
  input  logic                   rst_n_i,
  input  logic                   valid_i,
  input  rv_core_pkg::addr_t     pc_i,
  input  rv_core_pkg::inst_t     inst_i,
  input  logic                   wena_i,
  input  rv_core_pkg::reg_addr_t waddr_i,
  input  rv_core_pkg::xlen_t     wdata_i,
  output logic                   valid_o,
  output rv_core_pkg::addr_t     pc_o,
  output rv_core_pkg::xlen_t     imm_o,
  output rv_core_pkg::xlen_t     rdata1_o,
  output rv_core_pkg::xlen_t     rdata2_o,
  output rv_isa_pkg::alu_op_t    alu_op_o,
  output rv_isa_pkg::br_op_t     br_op_o,
  output logic                   sel_pc_o,
  output logic                   sel_imm_o,
  output logic                   wena_o,
  output rv_core_pkg::reg_addr_t waddr_o
);

  import rv_core_pkg::*;
  import rv_isa_pkg::*;

  opcode_t   opcode;
  reg_addr_t rd;
  xlen_t     imm_i_type;
  xlen_t     imm_u_type;
  xlen_t     imm_b_type;
  xlen_t     imm_j_type;
  xlen_t     rs1_data;
  xlen_t     rs2_data;
  xlen_t     imm;
  alu_op_t   f3_op;
  alu_op_t   alu_op;
  br_op_t    br_op;
  logic      sel_pc;
  logic      sel_imm;
  logic      wena;

  assign opcode = opcode_t'(inst_i[6:0]);
  assign rd     = inst_i[11:7];

  assign imm_i_type = {{20{inst_i[31]}}, inst_i[31:20]};
  assign imm_u_type = {inst_i[31:12], 12'b0};
  assign imm_b_type = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
  assign imm_j_type = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

  regfile regfile0 (
    .clock    (clock),
    .rst_n_i  (rst_n_i),
    .raddr1_i (inst_i[19:15]),
    .raddr2_i (inst_i[24:20]),
    .rdata1_o (rs1_data),
    .rdata2_o (rs2_data),
    .wena_i   (wena_i),
    .waddr_i  (waddr_i),
    .wdata_i  (wdata_i)
  );

  // funct7 bit 30 picks sub, only for register ops.
  always_comb begin
    case (funct3_t'(inst_i[14:12]))
      F3_ADD:  f3_op = (opcode == OP && inst_i[30]) ? ALU_SUB : ALU_ADD;
      F3_SLL:  f3_op = ALU_SLL;
      F3_SLT:  f3_op = ALU_SLT;
      F3_XOR:  f3_op = ALU_XOR;
      F3_SRL:  f3_op = ALU_SRL;
      F3_OR:   f3_op = ALU_OR;
      F3_AND:  f3_op = ALU_AND;
      default: f3_op = ALU_ADD;
    endcase
  end

  always_comb begin
    alu_op  = ALU_ADD;
    br_op   = BR_NONE;
    sel_pc  = 1'b0;
    sel_imm = 1'b0;
    wena    = 1'b0;
    imm     = imm_i_type;
    case (opcode)
      OP_IMM: begin
        alu_op  = f3_op;
        sel_imm = 1'b1;
        wena    = 1'b1;
      end
      OP: begin
        alu_op = f3_op;
        wena   = 1'b1;
      end
      LUI: begin
        alu_op  = ALU_PASS_B;
        sel_imm = 1'b1;
        imm     = imm_u_type;
        wena    = 1'b1;
      end
      AUIPC: begin
        sel_pc  = 1'b1;
        sel_imm = 1'b1;
        imm     = imm_u_type;
        wena    = 1'b1;
      end
      JAL: begin
        br_op = BR_JUMP;
        imm   = imm_j_type;
        wena  = 1'b1;
      end
      BRANCH: begin
        imm = imm_b_type;
        case (inst_i[14:12])
          F3_BEQ:  br_op = BR_EQ;
          F3_BNE:  br_op = BR_NE;
          default: br_op = BR_NONE;
        endcase
      end
      default: ;
    endcase
  end

  always_ff @(posedge clock) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  // x0 is never written.
  always_ff @(posedge clock) begin
    if (valid_i) begin
      pc_o      <= pc_i;
      imm_o     <= imm;
      rdata1_o  <= rs1_data;
      rdata2_o  <= rs2_data;
      alu_op_o  <= alu_op;
      br_op_o   <= br_op;
      sel_pc_o  <= sel_pc;
      sel_imm_o <= sel_imm;
      wena_o    <= wena && (rd != '0);
      waddr_o   <= rd;
    end
  end

endmodule

// File: verilog/execute.sv
`timescale 1ns/100ps

module execute (
  input  logic                   clock,
  input  logic                   rst_n_i,
  input  logic                   valid_i,
  input  rv_core_pkg::addr_t     pc_i,
  input  rv_core_pkg::xlen_t     imm_i,
  input  rv_core_pkg::xlen_t     rdata1_i,
  input  rv_core_pkg::xlen_t     rdata2_i,
  input  rv_isa_pkg::alu_op_t    alu_op_i,
  input  rv_isa_pkg::br_op_t     br_op_i,
  input  logic                   sel_pc_i,
  input  logic                   sel_imm_i,
  input  logic                   wena_i,
  input  rv_core_pkg::reg_addr_t waddr_i,
  output logic                   valid_o,
  output rv_core_pkg::addr_t     pc_o,
  output rv_core_pkg::xlen_t     result_o,
  output rv_core_pkg::addr_t     next_pc_o,
  output logic                   wena_o,
  output rv_core_pkg::reg_addr_t waddr_o
);

  import rv_core_pkg::*;
  import rv_isa_pkg::*;

  xlen_t op_a;
  xlen_t op_b;
  xlen_t alu_out;
  addr_t pc_plus4;
  logic  taken;

  assign op_a     = sel_pc_i ? pc_i : rdata1_i;
  assign op_b     = sel_imm_i ? imm_i : rdata2_i;
  assign pc_plus4 = pc_i + 32'd4;

  always_comb begin
    case (alu_op_i)
      ALU_ADD:    alu_out = op_a + op_b;
      ALU_SUB:    alu_out = op_a - op_b;
      ALU_SLL:    alu_out = op_a << op_b[4:0];
      ALU_SRL:    alu_out = op_a >> op_b[4:0];
      ALU_SLT:    alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
      ALU_XOR:    alu_out = op_a ^ op_b;
      ALU_OR:     alu_out = op_a | op_b;
      ALU_AND:    alu_out = op_a & op_b;
      ALU_PASS_B: alu_out = op_b;
      default:    alu_out = op_a + op_b;
    endcase
  end

  // branches compare the raw register values.
  always_comb begin
    case (br_op_i)
      BR_EQ:   taken = (rdata1_i == rdata2_i);
      BR_NE:   taken = (rdata1_i != rdata2_i);
      BR_JUMP: taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clock) begin
    if (valid_i) begin
      pc_o      <= pc_i;
      result_o  <= (br_op_i == BR_JUMP) ? pc_plus4 : alu_out;
      next_pc_o <= taken ? pc_i + imm_i : pc_plus4;
      wena_o    <= wena_i;
      waddr_o   <= waddr_i;
    end
  end

endmodule

// File: verilog/fetch.sv
`timescale 1ns/100ps
`include "rv_config.svh"

module fetch (
  input  logic                   clock,
  input  logic                   rst_n_i,
  input  logic                   commit_valid_i,
  input  rv_core_pkg::addr_t     next_pc_i,
  input  logic                   arready_i,
  output logic                   arvalid_o,
  output rv_core_pkg::addr_t     araddr_o,
  output logic                   rready_o,
  input  logic                   rvalid_i,
  input  rv_core_pkg::bus_data_t rdata_i,
  output logic                   valid_o,
  output rv_core_pkg::addr_t     pc_o,
  output rv_core_pkg::inst_t     inst_o
);

  import rv_core_pkg::*;

  fetch_state_t state_q;
  addr_t        pc_q;
  logic         arvalid_q;
  logic         valid_q;
  inst_t        inst_q;

  always_ff @(posedge clock) begin
    if (!rst_n_i) begin
      state_q   <= F_ADDR;
      pc_q      <= `RV_RESET_PC;
      arvalid_q <= 1'b0;
      valid_q   <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      case (state_q)
        F_ADDR: begin
          if (arvalid_q && arready_i) begin
            arvalid_q <= 1'b0;
            state_q   <= F_DATA;
          end else begin
            // first request after reset.
            arvalid_q <= 1'b1;
          end
        end
        F_DATA: begin
          if (rvalid_i) begin
            valid_q <= 1'b1;
            state_q <= F_WAIT;
          end
        end
        F_WAIT: begin
          // wait for the retire, then go straight to the next request.
          if (commit_valid_i) begin
            pc_q      <= next_pc_i;
            arvalid_q <= 1'b1;
            state_q   <= F_ADDR;
          end
        end
        default: state_q <= F_ADDR;
      endcase
    end
  end

  // bit 2 selects the word within the beat.
  always_ff @(posedge clock) begin
    if (state_q == F_DATA && rvalid_i) begin
      inst_q <= pc_q[2] ? rdata_i[63:32] : rdata_i[31:0];
    end
  end

  assign arvalid_o = arvalid_q;
  assign araddr_o  = pc_q;
  assign rready_o  = (state_q == F_DATA);
  assign valid_o   = valid_q;
  assign pc_o      = pc_q;
  assign inst_o    = inst_q;

endmodule

// File: verilog/regfile.sv
`timescale 1ns/100ps
`include "rv_config.svh"

module regfile (
  input  logic                   clock,
  input  logic                   rst_n_i,
  input  rv_core_pkg::reg_addr_t raddr1_i,
  input  rv_core_pkg::reg_addr_t raddr2_i,
  output rv_core_pkg::xlen_t     rdata1_o,
  output rv_core_pkg::xlen_t     rdata2_o,
  input  logic                   wena_i,
  input  rv_core_pkg::reg_addr_t waddr_i,
  input  rv_core_pkg::xlen_t     wdata_i
);

  import rv_core_pkg::*;

  xlen_t regs [`RV_REG_COUNT];

  always_ff @(posedge clock) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `RV_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wena_i && waddr_i != '0) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // x0 reads as zero.
  assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
  assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

// File: verilog/rv_config.svh
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// datapath width.
`define RV_XLEN 32

// byte address and pc width.
`define RV_ADDR_WIDTH 32

// one read beat holds two instructions.
`define RV_BUS_WIDTH 64

// architectural registers.
`define RV_REG_COUNT 32

// first fetch address.
`define RV_RESET_PC 32'h8000_0000

`endif

// File: verilog/rv_core_pkg.sv
`include "rv_config.svh"

package rv_core_pkg;

  // register or alu value.
  typedef logic [`RV_XLEN-1:0] xlen_t;

  // byte address or pc.
  typedef logic [`RV_ADDR_WIDTH-1:0] addr_t;

  typedef logic [$clog2(`RV_REG_COUNT)-1:0] reg_addr_t;

  typedef logic [31:0] inst_t;

  // one beat of the read channel.
  typedef logic [`RV_BUS_WIDTH-1:0] bus_data_t;

  typedef enum logic [1:0] {
    F_ADDR,
    F_DATA,
    F_WAIT
  } fetch_state_t;

endpackage

// File: verilog/rv_isa_pkg.sv
package rv_isa_pkg;

  typedef enum logic [6:0] {
    OP_IMM = 7'b0010011,
    OP     = 7'b0110011,
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    BRANCH = 7'b1100011
  } opcode_t;

  // funct3 of the integer register and immediate ops.
  typedef enum logic [2:0] {
    F3_ADD = 3'b000,
    F3_SLL = 3'b001,
    F3_SLT = 3'b010,
    F3_XOR = 3'b100,
    F3_SRL = 3'b101,
    F3_OR  = 3'b110,
    F3_AND = 3'b111
  } funct3_t;

  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SRL,
    ALU_SLT,
    ALU_XOR,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_t;

  typedef enum logic [1:0] {
    BR_NONE,
    BR_EQ,
    BR_NE,
    BR_JUMP
  } br_op_t;

endpackage
